//--- tb.f
+incdir+test
verilog/controlPkg.sv
verilog/decodeIf.sv
verilog/instrDecoder.sv
verilog/stateSequencer.sv
verilog/controlDriver.sv
verilog/controller.sv
test/controllerTb.sv

//--- test/controllerModel.svh
`ifndef CONTROLLER_MODEL_SVH
`define CONTROLLER_MODEL_SVH

typedef struct packed {
    logic               instrWrite;
    logic               newAluInput;
    logic               psrRegEn;
    logic               regWrite;
    logic               memWrite;
    logic               writeBackSelect;
    logic               dataToWriteSelect;
    logic               pcEn;
    controlPkg::muxSelT aluSrc1Sel;
    controlPkg::muxSelT aluSrc2Sel;
    controlPkg::muxSelT pcSrc;
} expectT;

// instruction class as the encoding tables define it
function automatic controlPkg::instrClassT classify(input logic [3:0] o, input logic [3:0] e,
        input logic [3:0] c);
    case (o)
        controlPkg::OP_REG:
            case (e)
                controlPkg::EXT_CMP: return controlPkg::CLS_CMP;
                controlPkg::EXT_MOV: return controlPkg::CLS_MOV;
                controlPkg::EXT_AND, controlPkg::EXT_OR, controlPkg::EXT_XOR,
                controlPkg::EXT_ADD, controlPkg::EXT_SUB: return controlPkg::CLS_ALU_REG;
                default: return controlPkg::CLS_NOP;
            endcase
        controlPkg::OP_SHIFT:
            return (e == controlPkg::EXT_LSH) ? controlPkg::CLS_ALU_REG : controlPkg::CLS_ALU_IMM;
        controlPkg::OP_MEM:
            case (e)
                controlPkg::EXT_LOAD:  return controlPkg::CLS_LOAD;
                controlPkg::EXT_STOR:  return controlPkg::CLS_STOR;
                controlPkg::EXT_JAL:   return controlPkg::CLS_JAL;
                controlPkg::EXT_JCOND: return (c == 4'd15) ? controlPkg::CLS_NOP : controlPkg::CLS_BRANCH;
                default:               return controlPkg::CLS_NOP;
            endcase
        controlPkg::OP_BCOND: return (c == 4'd15) ? controlPkg::CLS_NOP : controlPkg::CLS_BRANCH;
        controlPkg::OP_ANDI, controlPkg::OP_ORI, controlPkg::OP_XORI, controlPkg::OP_ADDI,
        controlPkg::OP_SUBI, controlPkg::OP_LUI: return controlPkg::CLS_ALU_IMM;
        controlPkg::OP_CMPI: return controlPkg::CLS_CMPI;
        controlPkg::OP_MOVI: return controlPkg::CLS_MOVI;
        default: return controlPkg::CLS_NOP;
    endcase
endfunction

function automatic logic condRule(input logic [3:0] c, input logic [7:0] p);
    logic g;
    logic z;
    logic f;
    logic l;
    logic cy;
    g  = p[controlPkg::FLAG_G];
    z  = p[controlPkg::FLAG_Z];
    f  = p[controlPkg::FLAG_F];
    l  = p[controlPkg::FLAG_L];
    cy = p[controlPkg::FLAG_C];
    case (c)
        4'd0:    return z;           // eq
        4'd1:    return !z;
        4'd2:    return cy;          // cs
        4'd3:    return !cy;
        4'd4:    return l;           // hi
        4'd5:    return !l;
        4'd6:    return g;           // gt
        4'd7:    return !g;
        4'd8:    return f;           // fs
        4'd9:    return !f;
        4'd10:   return !l && !z;    // lo
        4'd11:   return l || z;
        4'd12:   return !g && !z;    // lt
        4'd13:   return z || g;
        4'd14:   return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic controlPkg::ctrlStateT nextOf(input controlPkg::ctrlStateT s,
        input controlPkg::instrClassT cls);
    case (s)
        controlPkg::FETCH: return controlPkg::DECODE;
        controlPkg::DECODE:
            case (cls)
                controlPkg::CLS_LOAD, controlPkg::CLS_STOR: return controlPkg::MEM_ADDR;
                controlPkg::CLS_JAL:    return controlPkg::JAL_REG;
                controlPkg::CLS_BRANCH: return controlPkg::BRANCH;
                controlPkg::CLS_NOP:    return controlPkg::PC_INCR;
                default:                return controlPkg::LOAD_OPS;
            endcase
        controlPkg::LOAD_OPS:
            return (cls == controlPkg::CLS_CMP || cls == controlPkg::CLS_CMPI) ?
                controlPkg::CMP_EX : controlPkg::ALU_EX;
        controlPkg::ALU_EX:   return controlPkg::WRITEBACK;
        controlPkg::MEM_ADDR:
            return (cls == controlPkg::CLS_STOR) ? controlPkg::MEM_WRITE : controlPkg::MEM_READ;
        controlPkg::MEM_READ: return controlPkg::LOAD_WB;
        controlPkg::JAL_REG:  return controlPkg::JAL_LINK;
        controlPkg::JAL_LINK: return controlPkg::JAL_JUMP;
        controlPkg::JAL_JUMP, controlPkg::BRANCH, controlPkg::PC_INCR: return controlPkg::PC_PAD1;
        controlPkg::PC_PAD1:  return controlPkg::PC_PAD2;
        controlPkg::PC_PAD2:  return controlPkg::FETCH;
        default:              return controlPkg::PC_INCR; // cmp, writeback, memory end
    endcase
endfunction

function automatic expectT expectOut(input controlPkg::ctrlStateT s,
        input controlPkg::instrClassT cls, input logic taken, input logic absolute);
    expectT x;
    logic move;
    logic imm;
    x    = '0;
    move = (cls == controlPkg::CLS_MOV) || (cls == controlPkg::CLS_MOVI);
    imm  = (cls == controlPkg::CLS_ALU_IMM) || (cls == controlPkg::CLS_CMPI) ||
           (cls == controlPkg::CLS_MOVI);
    case (s)
        controlPkg::FETCH: x.instrWrite = 1'b1;
        controlPkg::LOAD_OPS, controlPkg::MEM_ADDR, controlPkg::JAL_REG: x.newAluInput = 1'b1;
        controlPkg::ALU_EX, controlPkg::CMP_EX:
        begin
            x.aluSrc1Sel = move ? controlPkg::SEL_ZERO : controlPkg::SEL_IMM;
            x.aluSrc2Sel = imm ? controlPkg::SEL_IMM : controlPkg::SEL_REG;
            x.psrRegEn   = (s == controlPkg::CMP_EX);
        end
        controlPkg::WRITEBACK: x.regWrite = 1'b1;
        controlPkg::MEM_WRITE: x.memWrite = 1'b1;
        controlPkg::LOAD_WB:
        begin
            x.regWrite        = 1'b1;
            x.writeBackSelect = 1'b1;
        end
        controlPkg::JAL_LINK:
        begin
            x.regWrite          = 1'b1;
            x.dataToWriteSelect = 1'b1;
        end
        controlPkg::JAL_JUMP:
        begin
            x.pcEn  = 1'b1;
            x.pcSrc = controlPkg::PC_ABS;
        end
        controlPkg::PC_INCR: x.pcEn = 1'b1;
        controlPkg::BRANCH:
        begin
            x.pcEn = 1'b1;
            if (taken)
                x.pcSrc = absolute ? controlPkg::PC_ABS : controlPkg::PC_REL;
        end
        default: ;
    endcase
    return x;
endfunction

`endif

//--- test/controllerTb.sv
`timescale 1ns/1ps

module controllerTb;

    localparam int aluCount     = 60;
    localparam int memCount     = 30;
    localparam int jalCount     = 10;
    localparam int branchRepeat = 3; // per condition code and branch kind
    localparam int instrCount   = 1 + aluCount + memCount + jalCount + 32 * branchRepeat;
    localparam int cycleLimit   = 8 * instrCount + 50;

    logic       clk;
    logic       reset;
    logic [3:0] op;
    logic [3:0] opExt;
    logic [3:0] cond;
    logic [7:0] psr;
    logic       instrWrite;
    logic       newAluInput;
    logic       psrRegEn;
    logic       regWrite;
    logic       memWrite;
    logic       writeBackSelect;
    logic       dataToWriteSelect;
    logic       pcEn;
    logic [1:0] aluSrc1Sel;
    logic [1:0] aluSrc2Sel;
    logic [1:0] pcSrc;

    int cycleCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testsPassed = 0;
    int testsFailed = 0;

    // what the last instruction showed on the outputs
    int cycles;
    int regWriteSeen;
    int memWriteSeen;
    int psrEnSeen;
    int pcEnSeen;
    int pcEnAt; // the pc update is followed by the two pads
    int newAluAt;
    int wbSelAt;
    int linkAt;
    int jumpAt;
    logic [1:0] pcSrcSeen;

    `include "controllerModel.svh"

    controller uut (.*);

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("run timed out after %0d cycles, an instruction never finished", cycleCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic expectValue(input string name, input logic [1:0] expected,
            input logic [1:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("Fail at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic expectCount(input string name, input int expected, input int actual);
        checkCount++;
        if (actual != expected)
        begin
            errorCount++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic compareOutputs(input expectT x);
        expectValue("instrWrite", x.instrWrite, instrWrite);
        expectValue("newAluInput", x.newAluInput, newAluInput);
        expectValue("psrRegEn", x.psrRegEn, psrRegEn);
        expectValue("regWrite", x.regWrite, regWrite);
        expectValue("memWrite", x.memWrite, memWrite);
        expectValue("writeBackSelect", x.writeBackSelect, writeBackSelect);
        expectValue("dataToWriteSelect", x.dataToWriteSelect, dataToWriteSelect);
        expectValue("pcEn", x.pcEn, pcEn);
        expectValue("aluSrc1Sel", x.aluSrc1Sel, aluSrc1Sel);
        expectValue("aluSrc2Sel", x.aluSrc2Sel, aluSrc2Sel);
        expectValue("pcSrc", x.pcSrc, pcSrc);
    endtask

    // per-class effects over the whole instruction
    task automatic verifyEffects(input controlPkg::instrClassT cls, input logic taken,
            input logic absolute);
        case (cls)
            controlPkg::CLS_CMP, controlPkg::CLS_CMPI:
            begin
                expectCount("newAluInput cycle", 2, newAluAt);
                expectCount("psrRegEn count", 1, psrEnSeen);
                expectCount("regWrite count", 0, regWriteSeen);
                expectCount("cycles", 7, pcEnAt + 3);
            end
            controlPkg::CLS_LOAD:
            begin
                expectCount("writeBackSelect cycle", 4, wbSelAt); // third after DECODE
                expectCount("regWrite count", 1, regWriteSeen);
                expectCount("cycles", 8, pcEnAt + 3);
            end
            controlPkg::CLS_STOR:
            begin
                expectCount("memWrite count", 1, memWriteSeen);
                expectCount("regWrite count", 0, regWriteSeen);
                expectCount("cycles", 7, pcEnAt + 3);
            end
            controlPkg::CLS_JAL:
            begin
                expectCount("link cycle", 3, linkAt);
                expectCount("jump cycle", 4, jumpAt);
                expectCount("cycles", 7, pcEnAt + 3);
            end
            controlPkg::CLS_BRANCH, controlPkg::CLS_NOP:
            begin
                expectCount("pcEn count", 1, pcEnSeen);
                expectValue("pcSrc when pcEn",
                    (!taken || cls == controlPkg::CLS_NOP) ? controlPkg::PC_NEXT :
                    absolute ? controlPkg::PC_ABS : controlPkg::PC_REL, pcSrcSeen);
                expectCount("cycles", 5, pcEnAt + 3);
            end
            default:
            begin
                expectCount("newAluInput cycle", 2, newAluAt);
                expectCount("regWrite count", 1, regWriteSeen);
                expectCount("psrRegEn count", 0, psrEnSeen);
                expectCount("cycles", 8, pcEnAt + 3);
            end
        endcase
    endtask

    // starts on the edge that enters FETCH and returns on the edge of the next one
    task automatic runInstr(input logic [3:0] o, input logic [3:0] e, input logic [3:0] c,
            input logic [7:0] p);
        controlPkg::ctrlStateT s;
        controlPkg::instrClassT cls;
        op    <= o;
        opExt <= e;
        cond  <= c;
        psr   <= p;
        cls = classify(o, e, c);
        s = controlPkg::FETCH;
        cycles = 0;
        regWriteSeen = 0;
        memWriteSeen = 0;
        psrEnSeen = 0;
        pcEnSeen = 0;
        pcEnAt = -1;
        newAluAt = -1;
        wbSelAt = -1;
        linkAt = -1;
        jumpAt = -1;
        pcSrcSeen = 2'b11;
        do
        begin
            @(negedge clk);
            compareOutputs(expectOut(s, cls, condRule(c, p), o == controlPkg::OP_MEM));
            regWriteSeen += (regWrite === 1'b1);
            memWriteSeen += (memWrite === 1'b1);
            psrEnSeen    += (psrRegEn === 1'b1);
            pcEnSeen     += (pcEn === 1'b1);
            if (newAluInput === 1'b1)
                newAluAt = cycles;
            if (writeBackSelect === 1'b1 && regWrite === 1'b1)
                wbSelAt = cycles;
            if (dataToWriteSelect === 1'b1 && regWrite === 1'b1)
                linkAt = cycles;
            if (pcEn === 1'b1)
            begin
                pcSrcSeen = pcSrc;
                pcEnAt    = cycles;
            end
            if (pcEn === 1'b1 && pcSrc === controlPkg::PC_ABS)
                jumpAt = cycles;
            cycles++;
            @(posedge clk);
            s = nextOf(s, cls);
        end
        while (s != controlPkg::FETCH);
        verifyEffects(cls, condRule(c, p), o == controlPkg::OP_MEM);
    endtask

    // mostly defined alu, move and compare encodings with the odd random one
    task automatic drawAluInstr(output logic [3:0] o, output logic [3:0] e);
        logic [31:0] rnd;
        rnd = $urandom;
        o = controlPkg::OP_REG;
        e = rnd[7:4];
        case (rnd[3:0])
            4'd0:  e = controlPkg::EXT_AND;
            4'd1:  e = controlPkg::EXT_OR;
            4'd2:  e = controlPkg::EXT_XOR;
            4'd3:  e = controlPkg::EXT_ADD;
            4'd4:  e = controlPkg::EXT_SUB;
            4'd5:  e = controlPkg::EXT_CMP;
            4'd6:  e = controlPkg::EXT_MOV;
            4'd7:
            begin
                o = controlPkg::OP_SHIFT;
                e = controlPkg::EXT_LSH;
            end
            4'd8:  o = controlPkg::OP_SHIFT;
            4'd9:  o = controlPkg::OP_ANDI;
            4'd10: o = rnd[8] ? controlPkg::OP_ORI : controlPkg::OP_XORI;
            4'd11: o = rnd[8] ? controlPkg::OP_ADDI : controlPkg::OP_SUBI;
            4'd12: o = controlPkg::OP_CMPI;
            4'd13: o = controlPkg::OP_MOVI;
            4'd14: o = controlPkg::OP_LUI;
            default: o = rnd[11:8];
        endcase
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore)
        begin
            testsPassed++;
            $display("test %s: ok", name);
        end
        else
        begin
            testsFailed++;
            $display("test %s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    initial
    begin
        logic [3:0]  o;
        logic [3:0]  e;
        logic [31:0] rnd;
        int errorsBefore;
        clk = 1'b0;
        reset <= 1'b0;
        op    <= 4'd0;
        opExt <= 4'd0;
        cond  <= 4'd0;
        psr   <= 8'd0;
        void'($urandom(32'he634_6681));

        errorsBefore = errorCount;
        @(posedge clk);
        @(negedge clk);
        compareOutputs(expectOut(controlPkg::FETCH, controlPkg::CLS_NOP, 1'b0, 1'b0));
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        runInstr(controlPkg::OP_REG, controlPkg::EXT_ADD, 4'd0, 8'd0); // FETCH right after reset
        reportTest("reset", errorsBefore);

        errorsBefore = errorCount;
        repeat (aluCount)
        begin
            drawAluInstr(o, e);
            rnd = $urandom;
            runInstr(o, e, rnd[3:0], rnd[11:4]);
        end
        reportTest("alu, move and compare", errorsBefore);

        errorsBefore = errorCount;
        repeat (memCount)
        begin
            rnd = $urandom;
            e = (rnd[14:12] < 3'd4) ? controlPkg::EXT_LOAD :
                (rnd[14:12] < 3'd7) ? controlPkg::EXT_STOR : rnd[19:16];
            runInstr(controlPkg::OP_MEM, e, rnd[3:0], rnd[11:4]);
        end
        reportTest("load and store", errorsBefore);

        errorsBefore = errorCount;
        repeat (jalCount)
        begin
            rnd = $urandom;
            runInstr(controlPkg::OP_MEM, controlPkg::EXT_JAL, rnd[3:0], rnd[11:4]);
        end
        reportTest("jump and link", errorsBefore);

        errorsBefore = errorCount;
        for (int kind = 0; kind < 2; kind++)
        begin
            for (int code = 0; code < 16; code++)
            begin
                repeat (branchRepeat)
                begin
                    rnd = $urandom;
                    if (kind == 0)
                        runInstr(controlPkg::OP_MEM, controlPkg::EXT_JCOND, code[3:0], rnd[11:4]);
                    else
                        runInstr(controlPkg::OP_BCOND, rnd[3:0], code[3:0], rnd[11:4]);
                end
            end
        end
        reportTest("jcond and bcond", errorsBefore);

        @(negedge clk);
        expectValue("instrWrite", 1'b1, instrWrite); // back in FETCH after the last one
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
            testsPassed, testsFailed, checkCount, errorCount);
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- verilog/controlDriver.sv
`timescale 1ns/1ps

module controlDriver (
    input  logic                  clk,
    input  logic                  reset,
    input  controlPkg::ctrlStateT state,
    decodeIf.driver               dec,
    input  controlPkg::psrT       psr,
    output logic                  instrWrite,
    output logic                  newAluInput,
    output logic                  psrRegEn,
    output logic                  regWrite,
    output logic                  memWrite,
    output logic                  writeBackSelect,
    output logic                  dataToWriteSelect,
    output logic                  pcEn,
    output controlPkg::muxSelT    aluSrc1Sel,
    output controlPkg::muxSelT    aluSrc2Sel,
    output controlPkg::muxSelT    pcSrc
);

    logic isMove; // mov or movi, latched when leaving DECODE
    logic taken;

    function automatic logic condHolds(input controlPkg::condT c, input controlPkg::psrT p);
        case (c)
            controlPkg::COND_EQ: return p[controlPkg::FLAG_Z];
            controlPkg::COND_NE: return !p[controlPkg::FLAG_Z];
            controlPkg::COND_GE: return p[controlPkg::FLAG_Z] || p[controlPkg::FLAG_G];
            controlPkg::COND_CS: return p[controlPkg::FLAG_C];
            controlPkg::COND_CC: return !p[controlPkg::FLAG_C];
            controlPkg::COND_HI: return p[controlPkg::FLAG_L];
            controlPkg::COND_LS: return !p[controlPkg::FLAG_L];
            controlPkg::COND_LO: return !p[controlPkg::FLAG_L] && !p[controlPkg::FLAG_Z];
            controlPkg::COND_HS: return p[controlPkg::FLAG_L] || p[controlPkg::FLAG_Z];
            controlPkg::COND_GT: return p[controlPkg::FLAG_G];
            controlPkg::COND_LE: return !p[controlPkg::FLAG_G];
            controlPkg::COND_FS: return p[controlPkg::FLAG_F];
            controlPkg::COND_FC: return !p[controlPkg::FLAG_F];
            controlPkg::COND_LT: return !p[controlPkg::FLAG_G] && !p[controlPkg::FLAG_Z];
            controlPkg::COND_UC: return 1'b1;
            default:             return 1'b0; // never
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        if (!reset)
            isMove <= 1'b0;
        else if (state == controlPkg::DECODE)
            isMove <= (dec.instrClass == controlPkg::CLS_MOV) ||
                      (dec.instrClass == controlPkg::CLS_MOVI);
    end

    assign taken = condHolds(dec.cond, psr);

    always_comb
    begin
        instrWrite        = 1'b0;
        newAluInput       = 1'b0;
        psrRegEn          = 1'b0;
        regWrite          = 1'b0;
        memWrite          = 1'b0;
        writeBackSelect   = 1'b0;
        dataToWriteSelect = 1'b0;
        pcEn              = 1'b0;
        aluSrc1Sel        = controlPkg::SEL_REG;
        aluSrc2Sel        = controlPkg::SEL_REG;
        pcSrc             = controlPkg::PC_NEXT;
        case (state)
            controlPkg::FETCH: instrWrite = 1'b1;
            controlPkg::LOAD_OPS, controlPkg::MEM_ADDR, controlPkg::JAL_REG:
                newAluInput = 1'b1;
            controlPkg::ALU_EX, controlPkg::CMP_EX:
            begin
                // moves add the source to zero
                aluSrc1Sel = isMove ? controlPkg::SEL_ZERO : controlPkg::SEL_IMM;
                aluSrc2Sel = dec.isImm ? controlPkg::SEL_IMM : controlPkg::SEL_REG;
                psrRegEn   = (state == controlPkg::CMP_EX);
            end
            controlPkg::WRITEBACK: regWrite = 1'b1;
            controlPkg::MEM_WRITE: memWrite = 1'b1;
            controlPkg::LOAD_WB:
            begin
                regWrite        = 1'b1;
                writeBackSelect = 1'b1; // memory data back to the register file
            end
            controlPkg::JAL_LINK:
            begin
                regWrite          = 1'b1;
                dataToWriteSelect = 1'b1; // link address
            end
            controlPkg::JAL_JUMP:
            begin
                pcEn  = 1'b1;
                pcSrc = controlPkg::PC_ABS;
            end
            controlPkg::PC_INCR: pcEn = 1'b1;
            controlPkg::BRANCH:
            begin
                pcEn = 1'b1; // not taken still steps to pc + 1
                if (taken)
                    pcSrc = dec.isAbsolute ? controlPkg::PC_ABS : controlPkg::PC_REL;
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (!reset) !(regWrite && memWrite));

    assert property (@(posedge clk) disable iff (!reset)
        !pcEn |-> pcSrc == controlPkg::PC_NEXT);

endmodule

//--- verilog/controlPkg.sv
package controlPkg;

    typedef logic [3:0] opcodeT;
    typedef logic [3:0] opExtT;
    typedef logic [3:0] condT;
    typedef logic [7:0] psrT;
    typedef logic [1:0] muxSelT;

    // primary opcodes
    localparam opcodeT OP_REG   = 4'b0000; // register alu group, opExt picks the op
    localparam opcodeT OP_ANDI  = 4'b0001;
    localparam opcodeT OP_ORI   = 4'b0010;
    localparam opcodeT OP_XORI  = 4'b0011;
    localparam opcodeT OP_MEM   = 4'b0100; // load, store, jal, jcond
    localparam opcodeT OP_ADDI  = 4'b0101;
    localparam opcodeT OP_SHIFT = 4'b1000;
    localparam opcodeT OP_SUBI  = 4'b1001;
    localparam opcodeT OP_CMPI  = 4'b1011;
    localparam opcodeT OP_BCOND = 4'b1100;
    localparam opcodeT OP_MOVI  = 4'b1101;
    localparam opcodeT OP_LUI   = 4'b1111;

    // extensions of the register group
    localparam opExtT EXT_AND = 4'b0001;
    localparam opExtT EXT_OR  = 4'b0010;
    localparam opExtT EXT_XOR = 4'b0011;
    localparam opExtT EXT_ADD = 4'b0101;
    localparam opExtT EXT_SUB = 4'b1001;
    localparam opExtT EXT_CMP = 4'b1011;
    localparam opExtT EXT_MOV = 4'b1101;

    localparam opExtT EXT_LSH = 4'b0100; // any other shift extension is lshi

    // extensions of the memory group
    localparam opExtT EXT_LOAD  = 4'b0000;
    localparam opExtT EXT_STOR  = 4'b0100;
    localparam opExtT EXT_JAL   = 4'b1000;
    localparam opExtT EXT_JCOND = 4'b1100;

    // branch conditions
    localparam condT COND_EQ = 4'd0;
    localparam condT COND_NE = 4'd1;
    localparam condT COND_CS = 4'd2;
    localparam condT COND_CC = 4'd3;
    localparam condT COND_HI = 4'd4;
    localparam condT COND_LS = 4'd5;
    localparam condT COND_GT = 4'd6;
    localparam condT COND_LE = 4'd7;
    localparam condT COND_FS = 4'd8;
    localparam condT COND_FC = 4'd9;
    localparam condT COND_LO = 4'd10;
    localparam condT COND_HS = 4'd11;
    localparam condT COND_LT = 4'd12;
    localparam condT COND_GE = 4'd13;
    localparam condT COND_UC = 4'd14;
    localparam condT COND_NV = 4'd15; // never taken

    // psr bit positions
    localparam int FLAG_G = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_F = 2;
    localparam int FLAG_L = 3;
    localparam int FLAG_C = 4;

    localparam muxSelT SEL_REG  = 2'b00;
    localparam muxSelT SEL_IMM  = 2'b01;
    localparam muxSelT SEL_ZERO = 2'b10;

    localparam muxSelT PC_NEXT = 2'b00;
    localparam muxSelT PC_ABS  = 2'b01;
    localparam muxSelT PC_REL  = 2'b10;

    typedef enum logic [3:0] {
        CLS_ALU_REG, CLS_ALU_IMM, CLS_CMP, CLS_CMPI, CLS_MOV, CLS_MOVI,
        CLS_LOAD, CLS_STOR, CLS_JAL, CLS_BRANCH, CLS_NOP
    } instrClassT;

    typedef enum logic [4:0] {
        FETCH, DECODE, LOAD_OPS, ALU_EX, CMP_EX, WRITEBACK, MEM_ADDR, MEM_READ,
        MEM_WRITE, LOAD_WB, JAL_REG, JAL_LINK, JAL_JUMP, BRANCH, PC_INCR,
        PC_PAD1, PC_PAD2
    } ctrlStateT;

endpackage

//--- verilog/controller.sv
`timescale 1ns/1ps

module controller (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] op,
    input  logic [3:0] opExt,
    input  logic [3:0] cond,
    input  logic [7:0] psr,
    output logic       instrWrite,
    output logic       newAluInput,
    output logic       psrRegEn,
    output logic       regWrite,
    output logic       memWrite,
    output logic       writeBackSelect,
    output logic       dataToWriteSelect,
    output logic       pcEn,
    output logic [1:0] aluSrc1Sel,
    output logic [1:0] aluSrc2Sel,
    output logic [1:0] pcSrc
);

    controlPkg::ctrlStateT state;

    decodeIf decBus ();

    instrDecoder decoder (
        .op    (op),
        .opExt (opExt),
        .cond  (cond),
        .dec   (decBus.decoder)
    );

    stateSequencer sequencer (
        .clk   (clk),
        .reset (reset),
        .dec   (decBus.sequencer),
        .state (state)
    );

    controlDriver driver (
        .clk               (clk),
        .reset             (reset),
        .state             (state),
        .dec               (decBus.driver),
        .psr               (psr),
        .instrWrite        (instrWrite),
        .newAluInput       (newAluInput),
        .psrRegEn          (psrRegEn),
        .regWrite          (regWrite),
        .memWrite          (memWrite),
        .writeBackSelect   (writeBackSelect),
        .dataToWriteSelect (dataToWriteSelect),
        .pcEn              (pcEn),
        .aluSrc1Sel        (aluSrc1Sel),
        .aluSrc2Sel        (aluSrc2Sel),
        .pcSrc             (pcSrc)
    );

endmodule

//--- verilog/decodeIf.sv
`timescale 1ns/1ps

// decoded instruction, stable from FETCH to the next FETCH
interface decodeIf;

    controlPkg::instrClassT instrClass;
    logic                   isImm;      // alu b operand is the immediate
    logic                   isAbsolute; // jcond rather than bcond
    controlPkg::condT       cond;

    modport decoder (
        output instrClass,
        output isImm,
        output isAbsolute,
        output cond
    );

    modport sequencer (
        input instrClass
    );

    // the class is needed here as well to latch the move flag
    modport driver (
        input instrClass,
        input isImm,
        input isAbsolute,
        input cond
    );

endinterface

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  controlPkg::opcodeT op,
    input  controlPkg::opExtT  opExt,
    input  controlPkg::condT   cond,
    decodeIf.decoder           dec
);

    assign dec.cond = cond;

    always_comb
    begin
        dec.instrClass = controlPkg::CLS_NOP; // undefined encodings just step the pc
        dec.isImm      = 1'b0;
        dec.isAbsolute = 1'b0;
        case (op)
            controlPkg::OP_REG:
            begin
                case (opExt)
                    controlPkg::EXT_AND, controlPkg::EXT_OR, controlPkg::EXT_XOR,
                    controlPkg::EXT_ADD, controlPkg::EXT_SUB:
                        dec.instrClass = controlPkg::CLS_ALU_REG;
                    controlPkg::EXT_CMP: dec.instrClass = controlPkg::CLS_CMP;
                    controlPkg::EXT_MOV: dec.instrClass = controlPkg::CLS_MOV;
                    default: dec.instrClass = controlPkg::CLS_NOP;
                endcase
            end
            controlPkg::OP_SHIFT:
            begin
                if (opExt == controlPkg::EXT_LSH)
                    dec.instrClass = controlPkg::CLS_ALU_REG;
                else
                begin
                    // shift amount comes from the immediate
                    dec.instrClass = controlPkg::CLS_ALU_IMM;
                    dec.isImm      = 1'b1;
                end
            end
            controlPkg::OP_MEM:
            begin
                case (opExt)
                    controlPkg::EXT_LOAD: dec.instrClass = controlPkg::CLS_LOAD;
                    controlPkg::EXT_STOR: dec.instrClass = controlPkg::CLS_STOR;
                    controlPkg::EXT_JAL:  dec.instrClass = controlPkg::CLS_JAL;
                    controlPkg::EXT_JCOND:
                    begin
                        dec.isAbsolute = 1'b1;
                        if (cond != controlPkg::COND_NV)
                            dec.instrClass = controlPkg::CLS_BRANCH;
                    end
                    default: dec.instrClass = controlPkg::CLS_NOP;
                endcase
            end
            controlPkg::OP_ANDI, controlPkg::OP_ORI, controlPkg::OP_XORI,
            controlPkg::OP_ADDI, controlPkg::OP_SUBI, controlPkg::OP_LUI:
            begin
                dec.instrClass = controlPkg::CLS_ALU_IMM;
                dec.isImm      = 1'b1;
            end
            controlPkg::OP_CMPI:
            begin
                dec.instrClass = controlPkg::CLS_CMPI;
                dec.isImm      = 1'b1;
            end
            controlPkg::OP_MOVI:
            begin
                dec.instrClass = controlPkg::CLS_MOVI;
                dec.isImm      = 1'b1;
            end
            controlPkg::OP_BCOND:
            begin
                if (cond != controlPkg::COND_NV) // never code falls to a plain pc step
                    dec.instrClass = controlPkg::CLS_BRANCH;
            end
            default: dec.instrClass = controlPkg::CLS_NOP;
        endcase
    end

endmodule

//--- verilog/stateSequencer.sv
`timescale 1ns/1ps

module stateSequencer (
    input  logic                  clk,
    input  logic                  reset,
    decodeIf.sequencer            dec,
    output controlPkg::ctrlStateT state
);

    controlPkg::ctrlStateT nextState;

    // successor of every state that does not look at the instruction class
    function automatic controlPkg::ctrlStateT successor(input controlPkg::ctrlStateT s);
        case (s)
            controlPkg::FETCH:     return controlPkg::DECODE;
            controlPkg::ALU_EX:    return controlPkg::WRITEBACK;
            controlPkg::CMP_EX:    return controlPkg::PC_INCR;
            controlPkg::WRITEBACK: return controlPkg::PC_INCR;
            controlPkg::MEM_READ:  return controlPkg::LOAD_WB;
            controlPkg::MEM_WRITE: return controlPkg::PC_INCR;
            controlPkg::LOAD_WB:   return controlPkg::PC_INCR;
            controlPkg::JAL_REG:   return controlPkg::JAL_LINK;
            controlPkg::JAL_LINK:  return controlPkg::JAL_JUMP;
            controlPkg::JAL_JUMP:  return controlPkg::PC_PAD1;
            controlPkg::BRANCH:    return controlPkg::PC_PAD1;
            controlPkg::PC_INCR:   return controlPkg::PC_PAD1;
            controlPkg::PC_PAD1:   return controlPkg::PC_PAD2;
            default:               return controlPkg::FETCH;
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        if (!reset)
            state <= controlPkg::FETCH;
        else
            state <= nextState;
    end

    always_comb
    begin
        case (state)
            controlPkg::DECODE:
            begin
                case (dec.instrClass)
                    controlPkg::CLS_ALU_REG, controlPkg::CLS_ALU_IMM, controlPkg::CLS_CMP,
                    controlPkg::CLS_CMPI, controlPkg::CLS_MOV, controlPkg::CLS_MOVI:
                        nextState = controlPkg::LOAD_OPS;
                    controlPkg::CLS_LOAD, controlPkg::CLS_STOR:
                        nextState = controlPkg::MEM_ADDR;
                    controlPkg::CLS_JAL:    nextState = controlPkg::JAL_REG;
                    controlPkg::CLS_BRANCH: nextState = controlPkg::BRANCH;
                    default:                nextState = controlPkg::PC_INCR;
                endcase
            end
            // class is held stable and the operand states fork on it again
            controlPkg::LOAD_OPS:
                nextState = (dec.instrClass == controlPkg::CLS_CMP ||
                             dec.instrClass == controlPkg::CLS_CMPI) ?
                            controlPkg::CMP_EX : controlPkg::ALU_EX;
            controlPkg::MEM_ADDR:
                nextState = (dec.instrClass == controlPkg::CLS_STOR) ?
                            controlPkg::MEM_WRITE : controlPkg::MEM_READ;
            default: nextState = successor(state);
        endcase
    end

    // fixed walk outside the class forks
    assert property (@(posedge clk) disable iff (!reset)
        (state != controlPkg::DECODE && state != controlPkg::LOAD_OPS &&
         state != controlPkg::MEM_ADDR) |=> state == successor($past(state)));

    // the forks see the same class that DECODE saw
    assert property (@(posedge clk) disable iff (!reset)
        (state == controlPkg::LOAD_OPS || state == controlPkg::MEM_ADDR) |->
            $stable(dec.instrClass));

endmodule
